//--- soc_pkg.sv
package soc_pkg;

    localparam int word_w = 16;
    localparam int dram_addr_w = 25;
    localparam int num_regs = 8;
    localparam int reg_w = $clog2(num_regs);
    localparam int step_cycles = 32;
    localparam int step_cnt_w = $clog2(step_cycles);

    // address map
    localparam logic [word_w-1:0] dram_last = 16'hF7FF;
    localparam logic [word_w-1:0] led_first = 16'hF800;
    localparam logic [word_w-1:0] led_last = 16'hF809;
    localparam logic [word_w-1:0] uart_ready_addr = 16'hF80A;
    localparam logic [word_w-1:0] uart_byte_addr = 16'hF80B;
    localparam logic [word_w-1:0] vga_write_addr = 16'hF80C;
    localparam logic [dram_addr_w-1:0] pix_base = 25'h80000;

    typedef enum logic [3:0] {
        op_halt = 4'd0,
        op_ldi = 4'd1,
        op_lui = 4'd2,
        op_add = 4'd3,
        op_sub = 4'd4,
        op_and = 4'd5,
        op_or = 4'd6,
        op_xor = 4'd7,
        op_ld = 4'd8,
        op_st = 4'd9,
        op_jmp = 4'd10,
        op_bz = 4'd11,
        op_nop = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        idle,
        fetch_instr,
        wait_ready,
        instr_out,
        rw_data,
        data_out
    } map_state_e;

    // three writes build one pixel
    typedef enum logic [1:0] {
        vga_x,
        vga_y,
        vga_bgr
    } vga_phase_e;

    typedef struct packed {
        opcode_e op;
        logic [reg_w-1:0] rd;
        logic [reg_w-1:0] rs;
        logic [reg_w-1:0] rt;
        logic [7:0] imm8;
    } decoded_t;

    typedef struct packed {
        logic [word_w-1:0] rs_val;
        logic [word_w-1:0] rt_val;
        logic [word_w-1:0] rd_val;
        logic [word_w-1:0] pc;
    } operands_t;

    typedef struct packed {
        logic wr_en;
        logic [reg_w-1:0] wr_reg;
        logic [word_w-1:0] wr_data;
        logic [word_w-1:0] next_pc;
        logic halt;
    } exec_t;

    typedef struct packed {
        logic [word_w-1:0] addr;
        logic [word_w-1:0] data;
        logic write;
    } mem_req_t;

    typedef struct packed {
        logic [dram_addr_w-1:0] addr;
        logic [word_w-1:0] data;
        logic write;
        logic refresh;
    } dram_req_t;

endpackage

//--- cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode
    import soc_pkg::*;
(
    input logic [word_w-1:0] instr,
    output decoded_t dec
);

    logic [3:0] raw_op;

    assign raw_op = instr[15:12];

    always_comb begin
        dec.rd = instr[11:9];
        dec.rs = instr[8:6];
        dec.rt = instr[5:3];
        dec.imm8 = instr[7:0];

        // unassigned codes fall back to nop
        case (raw_op)
            op_halt,
            op_ldi,
            op_lui,
            op_add,
            op_sub,
            op_and,
            op_or,
            op_xor,
            op_ld,
            op_st,
            op_jmp,
            op_bz,
            op_nop: dec.op = opcode_e'(raw_op);
            default: dec.op = op_nop;
        endcase
    end

endmodule

//--- cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute
    import soc_pkg::*;
(
    input decoded_t dec,
    input operands_t ops,
    input logic [word_w-1:0] read_data,
    output exec_t res,
    output mem_req_t req
);

    logic [word_w-1:0] seq_pc;
    logic [word_w-1:0] branch_off;

    assign seq_pc = ops.pc + 16'd1;
    // low six bits, sign extended
    assign branch_off = {{(word_w-6){dec.imm8[5]}}, dec.imm8[5:0]};

    always_comb begin
        res.wr_en = 1'b0;
        res.wr_reg = dec.rd;
        res.wr_data = '0;
        res.next_pc = seq_pc;
        res.halt = 1'b0;

        case (dec.op)
            op_ldi: begin
                res.wr_en = 1'b1;
                res.wr_data = {8'h00, dec.imm8};
            end
            op_lui: begin
                res.wr_en = 1'b1;
                res.wr_data = {dec.imm8, ops.rd_val[7:0]};
            end
            op_add: begin
                res.wr_en = 1'b1;
                res.wr_data = ops.rs_val + ops.rt_val;
            end
            op_sub: begin
                res.wr_en = 1'b1;
                res.wr_data = ops.rs_val - ops.rt_val;
            end
            op_and: begin
                res.wr_en = 1'b1;
                res.wr_data = ops.rs_val & ops.rt_val;
            end
            op_or: begin
                res.wr_en = 1'b1;
                res.wr_data = ops.rs_val | ops.rt_val;
            end
            op_xor: begin
                res.wr_en = 1'b1;
                res.wr_data = ops.rs_val ^ ops.rt_val;
            end
            op_ld: begin
                res.wr_en = 1'b1;
                res.wr_data = read_data;
            end
            op_jmp: res.next_pc = ops.rs_val;
            op_bz: begin
                if (ops.rd_val == '0) begin
                    res.next_pc = seq_pc + branch_off;
                end
            end
            op_halt: begin
                // stay on the halt word so it keeps being refetched
                res.next_pc = ops.pc;
                res.halt = 1'b1;
            end
            default: ;
        endcase
    end

    assign req.addr = ops.rs_val;
    assign req.data = ops.rt_val;
    assign req.write = (dec.op == op_st);

endmodule

//--- cpu_result.sv
`timescale 1ns/1ps

module cpu_result
    import soc_pkg::*;
(
    input logic clk,
    input logic rst,
    output operands_t ops,
    input decoded_t dec,
    input exec_t res,
    output logic step,
    output logic halted
);

    logic [word_w-1:0] regs [num_regs];
    logic [word_w-1:0] pc;
    logic [step_cnt_w-1:0] step_cnt;
    logic started;

    assign step = (step_cnt == step_cnt_w'(step_cycles - 1));

    assign ops.rs_val = regs[dec.rs];
    assign ops.rt_val = regs[dec.rt];
    assign ops.rd_val = regs[dec.rd];
    assign ops.pc = pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            pc <= '0;
            started <= 1'b0;
            halted <= 1'b0;
        end else if (step) begin
            // first strobe only kicks off the fetch at address 0
            if (!started) begin
                started <= 1'b1;
            end else if (!halted) begin
                if (res.wr_en) begin
                    regs[res.wr_reg] <= res.wr_data;
                end
                pc <= res.next_pc;
                halted <= res.halt;
            end
        end
    end

endmodule

//--- mem_map.sv
`timescale 1ns/1ps

module mem_map
    import soc_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic step,
    input logic halted,
    input logic [word_w-1:0] pc,
    input mem_req_t req,
    output logic [word_w-1:0] instr,
    output logic [word_w-1:0] read_data,
    output dram_req_t dram,
    input logic [word_w-1:0] dram_read_data,
    input logic dram_data_ready,
    output logic [9:0] led,
    output logic [7:0] uart_tx_byte,
    output logic uart_tx_start_n,
    input logic uart_tx_ready
);

    map_state_e state;
    vga_phase_e vga_phase;
    logic got_instr;
    logic got_data;
    logic [1:0] ready_hist;
    logic [9:0] pix_x;
    logic [8:0] pix_y;

    logic is_dram;
    logic is_led;
    logic write_ok;
    logic [3:0] led_off;

    assign is_dram = (req.addr <= dram_last);
    assign is_led = (req.addr >= led_first) && (req.addr <= led_last);
    // no writes of any kind once the core has stopped
    assign write_ok = req.write && !halted;
    assign led_off = req.addr[3:0] - led_first[3:0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= idle;
            vga_phase <= vga_x;
            got_instr <= 1'b0;
            got_data <= 1'b0;
            ready_hist <= 2'b11;
            dram.refresh <= 1'b0;
            dram.write <= 1'b0;
            led <= '0;
            uart_tx_start_n <= 1'b1;
            instr <= 16'hFFFF;
        end else begin
            // release start on a rising edge of ready
            ready_hist <= {ready_hist[0], uart_tx_ready};
            if (ready_hist == 2'b01) begin
                uart_tx_start_n <= 1'b1;
            end

            case (state)
                idle: begin
                    if (step) begin
                        state <= fetch_instr;
                    end
                end
                fetch_instr: begin
                    dram.refresh <= 1'b1;
                    dram.write <= 1'b0;
                    dram.addr <= (pc <= dram_last) ? {9'b0, pc} : '0;
                    got_instr <= 1'b0;
                    got_data <= 1'b0;
                    state <= wait_ready;
                end
                wait_ready: begin
                    dram.refresh <= 1'b0;
                    dram.write <= 1'b0;
                    // read data is only valid during the ready pulse
                    if (dram_data_ready && !got_instr) begin
                        instr <= dram_read_data;
                        state <= instr_out;
                    end else if (dram_data_ready && !got_data) begin
                        if (req.addr == uart_ready_addr) begin
                            read_data <= {15'b0, uart_tx_ready};
                        end else begin
                            read_data <= dram_read_data;
                        end
                        state <= data_out;
                    end else if (dram_data_ready) begin
                        state <= idle;
                    end
                end
                instr_out: begin
                    got_instr <= 1'b1;
                    state <= rw_data;
                end
                rw_data: begin
                    dram.refresh <= 1'b1;
                    dram.data <= req.data;
                    dram.addr <= is_dram ? {9'b0, req.addr} : '0;
                    dram.write <= write_ok && is_dram;

                    if (write_ok && is_led) begin
                        led[led_off] <= req.data[0];
                    end

                    if (write_ok && req.addr == uart_byte_addr) begin
                        uart_tx_byte <= req.data[7:0];
                        uart_tx_start_n <= 1'b0;
                    end

                    if (write_ok && req.addr == vga_write_addr) begin
                        case (vga_phase)
                            vga_x: begin
                                pix_x <= req.data[9:0];
                                vga_phase <= vga_y;
                            end
                            vga_y: begin
                                pix_y <= req.data[8:0];
                                vga_phase <= vga_bgr;
                            end
                            vga_bgr: begin
                                dram.addr <= pix_base + {6'b0, pix_y, pix_x};
                                dram.write <= 1'b1;
                                vga_phase <= vga_x;
                            end
                            default: vga_phase <= vga_x;
                        endcase
                    end
                    state <= wait_ready;
                end
                data_out: begin
                    got_data <= 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- soc_top.sv
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input logic clk,
    input logic rst,
    output dram_req_t dram_req,
    input logic [word_w-1:0] dram_read_data,
    input logic dram_data_ready,
    output logic [9:0] led,
    output logic [7:0] uart_tx_byte,
    output logic uart_tx_start_n,
    input logic uart_tx_ready,
    output logic halted
);

    logic [word_w-1:0] instr;
    logic [word_w-1:0] read_data;
    logic step;
    decoded_t dec;
    operands_t ops;
    exec_t res;
    mem_req_t req;

    cpu_decode u_decode (
        .instr(instr),
        .dec(dec)
    );

    cpu_execute u_execute (
        .dec(dec),
        .ops(ops),
        .read_data(read_data),
        .res(res),
        .req(req)
    );

    cpu_result u_result (
        .clk(clk),
        .rst(rst),
        .ops(ops),
        .dec(dec),
        .res(res),
        .step(step),
        .halted(halted)
    );

    mem_map u_mem_map (
        .clk(clk),
        .rst(rst),
        .step(step),
        .halted(halted),
        .pc(ops.pc),
        .req(req),
        .instr(instr),
        .read_data(read_data),
        .dram(dram_req),
        .dram_read_data(dram_read_data),
        .dram_data_ready(dram_data_ready),
        .led(led),
        .uart_tx_byte(uart_tx_byte),
        .uart_tx_start_n(uart_tx_start_n),
        .uart_tx_ready(uart_tx_ready)
    );

endmodule

//--- tb_dram.sv
`timescale 1ns/1ps

module tb_dram
    import soc_pkg::*;
(
    input logic clk,
    input logic rst,
    input dram_req_t req,
    input logic [31:0] rnd,
    output logic [word_w-1:0] read_data,
    output logic data_ready
);

    // only the low 64K words are stored, pixel writes are logged
    logic [word_w-1:0] mem [65536];
    logic [dram_addr_w-1:0] wr_addr [$];
    logic [word_w-1:0] wr_data [$];
    logic [dram_addr_w-1:0] pend_addr;
    int wait_cnt;

    initial begin
        data_ready = 1'b0;
        read_data = '0;
        wait_cnt = 0;
        pend_addr = '0;
        forever begin
            @(posedge clk);
            #2;
            data_ready = 1'b0;
            if (!rst) begin
                wait_cnt = 0;
                wr_addr.delete();
                wr_data.delete();
            end else begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                    if (wait_cnt == 0) begin
                        data_ready = 1'b1;
                        read_data = mem[pend_addr[15:0]];
                    end
                end
                if (req.refresh) begin
                    pend_addr = req.addr;
                    // ready comes 2 to 6 cycles after the request
                    wait_cnt = 2 + int'(rnd[20:16] % 5);
                    if (req.write) begin
                        if (req.addr < 25'h10000) begin
                            mem[req.addr[15:0]] = req.data;
                        end
                        wr_addr.push_back(req.addr);
                        wr_data.push_back(req.data);
                    end
                end
            end
        end
    end

endmodule

//--- tb_soc.sv
`timescale 1ns/1ps

module tb_soc
    import soc_pkg::*;
();

    logic clk;
    logic rst;
    dram_req_t dram_req;
    logic [word_w-1:0] dram_read_data;
    logic dram_data_ready;
    logic [9:0] led;
    logic [7:0] uart_tx_byte;
    logic uart_tx_start_n;
    logic uart_tx_ready;
    logic halted;

    logic [31:0] lcg_state;
    int ready_wait;
    logic prev_start_n;
    logic [7:0] uart_bytes [$];
    int cycle_limit;
    int cycles;
    bit parse_err;

    // records from the tests file, tagged with the test index
    string names [$];
    int budgets [$];
    logic [9:0] exp_led [$];
    int ld_test [$];
    logic [15:0] ld_addr [$];
    logic [15:0] ld_word [$];
    int eu_test [$];
    logic [7:0] eu_byte [$];
    int ew_test [$];
    logic [24:0] ew_addr [$];
    logic [15:0] ew_data [$];

    soc_top UUT (
        .clk(clk),
        .rst(rst),
        .dram_req(dram_req),
        .dram_read_data(dram_read_data),
        .dram_data_ready(dram_data_ready),
        .led(led),
        .uart_tx_byte(uart_tx_byte),
        .uart_tx_start_n(uart_tx_start_n),
        .uart_tx_ready(uart_tx_ready),
        .halted(halted)
    );

    tb_dram DRAM (
        .clk(clk),
        .rst(rst),
        .req(dram_req),
        .rnd(lcg_state),
        .read_data(dram_read_data),
        .data_ready(dram_data_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] mem_fill(input int a);
        return 16'(a) ^ 16'hC3A5;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // advanced on the falling edge so both users see a settled value
    initial begin
        lcg_state = 32'h3fef;
        forever begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
        end
    end

    // log each uart byte and hold ready low for a while
    initial begin
        uart_tx_ready = 1'b1;
        ready_wait = 0;
        prev_start_n = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            if (ready_wait > 0) begin
                ready_wait--;
                if (ready_wait == 0) begin
                    uart_tx_ready = 1'b1;
                end
            end
            if (prev_start_n && !uart_tx_start_n) begin
                uart_bytes.push_back(uart_tx_byte);
                uart_tx_ready = 1'b0;
                ready_wait = 3 + int'(lcg_state[18:16]);
            end
            prev_start_n = uart_tx_start_n;
        end
    end

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("Test FAILED");
        $finish;
    end

    task automatic read_tests();
        int fd;
        int r;
        int cnt;
        string kw;
        string line;
        string nm;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen("mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file mem_tests.txt");
            parse_err = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", kw);
            if (r != 1) break;
            case (kw)
                "#": r = $fgets(line, fd);
                "test": begin
                    r = $fscanf(fd, "%s %d", nm, cnt);
                    names.push_back(nm);
                    budgets.push_back(cnt);
                    exp_led.push_back('0);
                end
                "prog", "data": begin
                    r = $fscanf(fd, "%h %d", a, cnt);
                    for (int i = 0; i < cnt; i++) begin
                        r = $fscanf(fd, "%h", v);
                        ld_test.push_back(names.size() - 1);
                        ld_addr.push_back(a[15:0] + 16'(i));
                        ld_word.push_back(v[15:0]);
                    end
                end
                "expect_led": begin
                    r = $fscanf(fd, "%h", v);
                    exp_led[names.size() - 1] = v[9:0];
                end
                "expect_uart": begin
                    r = $fscanf(fd, "%d", cnt);
                    for (int i = 0; i < cnt; i++) begin
                        r = $fscanf(fd, "%h", v);
                        eu_test.push_back(names.size() - 1);
                        eu_byte.push_back(v[7:0]);
                    end
                end
                "expect_write": begin
                    r = $fscanf(fd, "%h %h", a, v);
                    ew_test.push_back(names.size() - 1);
                    ew_addr.push_back(a[24:0]);
                    ew_data.push_back(v[15:0]);
                end
                "end": ;
                default: begin
                    $display("unknown record %s in mem_tests.txt", kw);
                    parse_err = 1'b1;
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic load_test(input int t);
        for (int a = 0; a < 65536; a++) begin
            DRAM.mem[a] = mem_fill(a);
        end
        foreach (ld_test[i]) begin
            if (ld_test[i] == t) DRAM.mem[ld_addr[i]] = ld_word[i];
        end
    endtask

    task automatic check_test(input int t, output bit ok);
        logic [24:0] e_addr [$];
        logic [15:0] e_data [$];
        logic [7:0] e_byte [$];
        int n;
        ok = 1'b1;
        foreach (ew_test[i]) begin
            if (ew_test[i] == t) begin
                e_addr.push_back(ew_addr[i]);
                e_data.push_back(ew_data[i]);
            end
        end
        foreach (eu_test[i]) begin
            if (eu_test[i] == t) e_byte.push_back(eu_byte[i]);
        end

        n = (e_addr.size() < DRAM.wr_addr.size()) ? e_addr.size() : DRAM.wr_addr.size();
        for (int i = 0; i < n; i++) begin
            if (DRAM.wr_addr[i] !== e_addr[i]) begin
                $display("[ERROR] %s: dram_req.addr of write %0d expected %h got %h",
                         names[t], i, e_addr[i], DRAM.wr_addr[i]);
                ok = 1'b0;
            end
            if (DRAM.wr_data[i] !== e_data[i]) begin
                $display("[ERROR] %s: dram_req.data of write %0d expected %h got %h",
                         names[t], i, e_data[i], DRAM.wr_data[i]);
                ok = 1'b0;
            end
        end
        if (DRAM.wr_addr.size() < e_addr.size()) begin
            $display("%s: %0d of the expected dram writes never happened",
                     names[t], e_addr.size() - DRAM.wr_addr.size());
            ok = 1'b0;
        end else if (DRAM.wr_addr.size() > e_addr.size()) begin
            $display("%s: %0d dram writes more than expected",
                     names[t], DRAM.wr_addr.size() - e_addr.size());
            ok = 1'b0;
        end

        n = (e_byte.size() < uart_bytes.size()) ? e_byte.size() : uart_bytes.size();
        for (int i = 0; i < n; i++) begin
            if (uart_bytes[i] !== e_byte[i]) begin
                $display("[ERROR] %s: uart_tx_byte %0d expected %h got %h",
                         names[t], i, e_byte[i], uart_bytes[i]);
                ok = 1'b0;
            end
        end
        if (uart_bytes.size() != e_byte.size()) begin
            $display("%s: expected %0d uart bytes but %0d were sent",
                     names[t], e_byte.size(), uart_bytes.size());
            ok = 1'b0;
        end

        if (led !== exp_led[t]) begin
            $display("[ERROR] %s: led expected %h got %h", names[t], exp_led[t], led);
            ok = 1'b0;
        end
    endtask

    task automatic run_test(input int t, output bit ok);
        bit chk_ok;
        @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        ok = 1'b1;
        if (led !== 10'h000) begin
            $display("[ERROR] %s: led after reset expected %h got %h", names[t], 10'h000, led);
            ok = 1'b0;
        end
        if (uart_tx_start_n !== 1'b1) begin
            $display("[ERROR] %s: uart_tx_start_n after reset expected 1 got %h",
                     names[t], uart_tx_start_n);
            ok = 1'b0;
        end
        if (halted !== 1'b0) begin
            $display("[ERROR] %s: halted after reset expected 0 got %h", names[t], halted);
            ok = 1'b0;
        end
        load_test(t);
        uart_bytes.delete();
        rst = 1'b1;
        while (halted !== 1'b1) @(posedge clk);
        // a few more steps so any stray write after halt would show up
        repeat (4 * step_cycles) @(posedge clk);
        #2;
        check_test(t, chk_ok);
        ok = ok && chk_ok;
    endtask

    initial begin
        int passed;
        int failed;
        int limit;
        bit ok;
        rst = 1'b0;
        passed = 0;
        failed = 0;
        parse_err = 1'b0;
        cycle_limit = 0;
        read_tests();
        limit = 0;
        foreach (budgets[i]) limit += budgets[i] * step_cycles + 4;
        cycle_limit = 2 * limit + 1;
        for (int t = 0; t < names.size(); t++) begin
            run_test(t, ok);
            if (ok) begin
                passed++;
                $display("test %s: pass", names[t]);
            end else begin
                failed++;
                $display("test %s: fail", names[t]);
            end
        end
        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && !parse_err && names.size() > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- mem_tests.txt
# test <name> <step budget>, prog/data <hex addr> <word count> <hex words>
# expect_led <hex>, expect_uart <count> <hex bytes>, expect_write <hex addr> <hex data>
test alu 30
prog 0000 21
1234 2212 140F 2456 2E40 1C01 3650 91D8 3FF0 4650 91D8
3FF0 5650 91D8 3FF0 6650 91D8 3FF0 7650 91D8 0000
expect_led 000
expect_write 04000 6843
expect_write 04001 BC25
expect_write 04002 1204
expect_write 04003 563F
expect_write 04004 443B
end
test load_branch 40
prog 0000 13
2201 8440 1A01 3268 8640 1C06 B403 3918 44A8 A180 2E50 91E0 0000
data 0100 2
0005 0007
expect_led 000
expect_write 05000 0023
end
test halt 20
prog 0000 11
22F8 1401 9050 160B 26F8 187E 90E0 2A30 9160 0160 9160
expect_led 001
expect_uart 1 7E
expect_write 03000 007E
end
test leds 30
prog 0000 19
22F8 1401 9050 1603 3858 9110 1609 3858 9110 1603
3858 9100 1605 3858 9110 8A40 2E60 91E8 0000
expect_led 221
expect_write 06000 22F8
end
test uart 25
prog 0000 17
120A 22F8 140B 24F8 1648 8840 B83E 9098 1669 8840
B83E 9098 1621 8840 B83E 9098 0000
expect_led 000
expect_uart 3 48 69 21
end
test vga 30
prog 0000 21
120C 22F8 1405 9050 1403 9050 2E70 165A 91D8 14BC 240A
9050 1423 2401 9050 14A7 9050 140F 24F0 9050 0000
expect_led 000
expect_write 07000 005A
expect_write 80C05 0ABC
expect_write A9D23 F00F
end

//--- sim.f
soc_pkg.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
mem_map.sv
soc_top.sv
tb_dram.sv
tb_soc.sv

//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/tb_soc: sim.f *.sv
	verilator --binary -f sim.f --top-module tb_soc -o tb_soc

run: obj_dir/tb_soc
	./obj_dir/tb_soc | tee sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only -Wall --top-module soc_top soc_pkg.sv cpu_decode.sv \
		cpu_execute.sv cpu_result.sv mem_map.sv soc_top.sv

clean:
	rm -rf obj_dir sim.log
